// File: Bender.yml
package:
  name: mem_dep_pred

sources:
  - ss_cfg_pkg.sv
  - ss_types_pkg.sv
  - ssit_ram.sv
  - store_set.sv
  - ss_dispatch.sv
  - mem_dep_pred.sv
  - target: test
    include_dirs:
      - .
    files:
      - mdp_tb.sv

// File: build.f
+incdir+.
ss_cfg_pkg.sv
ss_types_pkg.sv
ssit_ram.sv
store_set.sv
ss_dispatch.sv
mem_dep_pred.sv
mdp_tb.sv

// File: mdp_ref_model.svh
// mirrors of the predictor tables.
ssit_entry_t          m_ssit [ssit_size];
logic [lfst_size-1:0] m_lfst_en;
logic [lfst_size-1:0] m_lfst_seen;
logic [rob_idx_w-1:0] m_lfst_idx [lfst_size];
logic [ssid_w-1:0]    m_set_cnt;
logic [ssit_clear_w-1:0] m_clear_cnt;

// lookups between sampling and the lfst read.
logic                          p1_valid, p2_valid;
lookup_req_t                   p1_req, p2_req;
ssit_entry_t [fetch_width-1:0] p1_ent, p2_ent;

dep_rsp_t exp_q [$];
string    name_q [$];

function automatic void model_reset();
    for (int i = 0; i < ssit_size; i++) begin
        m_ssit[i] = '0;
    end
    for (int i = 0; i < lfst_size; i++) begin
        m_lfst_idx[i] = '0;
    end
    m_lfst_en   = '0;
    m_lfst_seen = '0;
    m_set_cnt   = '0;
    m_clear_cnt = '0;
    p1_valid    = 1'b0;
    p2_valid    = 1'b0;
endfunction

function automatic void train_model(train_req_t t);
    ssit_entry_t ld;
    ssit_entry_t st;
    ssit_entry_t nxt;
    ld     = m_ssit[t.ld_idx];
    st     = m_ssit[t.st_idx];
    nxt.en = 1'b1;
    if (!ld.en && !st.en) begin
        nxt.ssid  = m_set_cnt; // fresh set.
        m_set_cnt = m_set_cnt + 1'b1;
    end else if (ld.en && st.en) begin
        nxt.ssid = (ld.ssid < st.ssid) ? ld.ssid : st.ssid;
    end else begin
        nxt.ssid = ld.en ? ld.ssid : st.ssid;
    end
    m_ssit[t.ld_idx] = nxt;
    m_ssit[t.st_idx] = nxt;
    if (ld.en || st.en) begin
        m_clear_cnt = m_clear_cnt + 1'b1;
        if (m_clear_cnt == 0) begin
            for (int i = 0; i < ssit_size; i++) begin
                m_ssit[i].en = 1'b0;
            end
        end
    end
endfunction

// expected response of one group at its lfst read.
function automatic dep_rsp_t expect_deps(lookup_req_t req, ssit_entry_t [fetch_width-1:0] ent,
                                         logic fin_clr, logic [ssid_w-1:0] fin_ssid);
    dep_rsp_t d;
    d = '0;
    for (int i = 0; i < fetch_width; i++) begin
        if (req[i].op != op_none && ent[i].en && m_lfst_en[ent[i].ssid] &&
            !(fin_clr && ent[i].ssid == fin_ssid)) begin
            d[i].dep_valid   = 1'b1;
            d[i].dep_rob_idx = m_lfst_idx[ent[i].ssid];
        end
    end
    if (req[0].op == op_store && ent[0].en && req[1].op != op_none && ent[1].en &&
        ent[0].ssid == ent[1].ssid) begin
        d[1].dep_valid   = 1'b1; // lane 0 store forwarded.
        d[1].dep_rob_idx = req[0].rob_idx;
    end
    return d;
endfunction

// File: mdp_tb.sv
`timescale 1ns/1ps

module mdp_tb;

    import ss_cfg_pkg::*;
    import ss_types_pkg::*;

    // lookups per test plus seven cycles per training.
    localparam int lookups_total  = 8 + 3 + 2 + 5 + 6 + 400;
    localparam int trains_total   = 10;
    localparam int timeout_cycles = (lookups_total + trains_total * 7) * 2 + 100;

    logic        clk;
    logic        rst;
    logic        lookup_valid;
    lookup_req_t lookup;
    logic        train_valid;
    train_req_t  train;
    logic        finish_valid;
    finish_req_t finish;
    logic        redirect;
    logic        rsp_valid;
    dep_rsp_t    rsp;
    string       cur_test;
    int          errors;
    int          cycle_cnt;

    `include "mdp_ref_model.svh"

    mem_dep_pred mem_dep_pred_i (
        .clk, .rst, .lookup_valid, .lookup, .train_valid, .train,
        .finish_valid, .finish, .redirect, .rsp_valid, .rsp
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // failure handling
    // ----------------------------------------
    task automatic stop_on_error();
        errors++;
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_dep(string name, dep_rsp_t exp, dep_rsp_t act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout, run did not end within %0d cycles", timeout_cycles);
            stop_on_error();
        end
    end

    // model steps on the same edge the dut samples.
    always @(posedge clk) begin
        if (rst) begin
            model_step();
        end
    end

    always @(negedge clk) begin
        if (rst && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected response %h with no lookup pending", rsp);
                stop_on_error();
            end else begin
                check_dep(name_q.pop_front(), exp_q.pop_front(), rsp);
            end
        end
    end

    function automatic void model_step();
        logic                 fin_clr;
        logic [lfst_size-1:0] wr;
        fin_clr = finish_valid && (m_lfst_idx[finish.ssid] == finish.rob_idx);
        wr = '0;
        if (p2_valid) begin
            exp_q.push_back(expect_deps(p2_req, p2_ent, fin_clr, finish.ssid));
            name_q.push_back(cur_test);
            for (int i = 0; i < fetch_width; i++) begin
                if (p2_req[i].op == op_store && p2_ent[i].en) begin
                    wr[p2_ent[i].ssid]          = 1'b1;
                    m_lfst_idx[p2_ent[i].ssid]  = p2_req[i].rob_idx; // lane 1 last.
                    m_lfst_seen[p2_ent[i].ssid] = 1'b1;
                end
            end
        end
        if (redirect) begin
            m_lfst_en = '0;
        end else begin
            m_lfst_en = m_lfst_en | wr;
            if (fin_clr) begin
                m_lfst_en[finish.ssid] = 1'b0;
            end
        end
        if (train_valid) begin
            train_model(train);
        end
        p2_valid = p1_valid;
        p2_req   = p1_req;
        p2_ent   = p1_ent;
        p1_valid = lookup_valid;
        p1_req   = lookup;
        for (int i = 0; i < fetch_width; i++) begin
            p1_ent[i] = m_ssit[lookup[i].ssit_idx];
        end
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    function automatic lookup_lane_t make_lane(mem_op_e op, int idx, int rob);
        lookup_lane_t l;
        l.op       = op;
        l.ssit_idx = idx;
        l.rob_idx  = rob;
        return l;
    endfunction

    task automatic apply_cycle(logic lv, lookup_req_t req, logic fv, finish_req_t f, logic rd);
        @(negedge clk);
        lookup_valid = lv;
        lookup       = req;
        train_valid  = 1'b0;
        train        = '0;
        finish_valid = fv;
        finish       = f;
        redirect     = rd;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) apply_cycle(1'b0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic send_lookup(lookup_lane_t l0, lookup_lane_t l1);
        lookup_req_t req;
        req[0] = l0;
        req[1] = l1;
        apply_cycle(1'b1, req, 1'b0, '0, 1'b0);
    endtask

    task automatic send_train(int ld, int st);
        idle_cycles(3);
        @(negedge clk);
        train_valid  = 1'b1;
        train.ld_idx = ld;
        train.st_idx = st;
        idle_cycles(3);
    endtask

    task automatic send_finish(int ssid, int rob);
        finish_req_t f;
        f.ssid    = ssid;
        f.rob_idx = rob;
        apply_cycle(1'b0, '0, 1'b1, f, 1'b0);
    endtask

    task automatic drain_responses();
        idle_cycles(3);
        while (exp_q.size() != 0) begin
            idle_cycles(1);
        end
    endtask

    task automatic run_random(int n_cycles);
        int          cyc;
        lookup_req_t req;
        finish_req_t f;
        logic        lv;
        logic        fv;
        logic        rd;
        cyc = 0;
        while (cyc < n_cycles) begin
            if ($urandom % 20 == 0) begin
                send_train($urandom % 16, $urandom % 16);
                cyc += 7;
            end else begin
                for (int i = 0; i < fetch_width; i++) begin
                    req[i] = make_lane(mem_op_e'($urandom % 3), $urandom % 16, $urandom % 8);
                end
                lv        = ($urandom % 4) != 0;
                f.ssid    = $urandom % lfst_size;
                f.rob_idx = $urandom % 8;
                fv        = ($urandom % 4 == 0) && m_lfst_seen[f.ssid]; // known index only.
                rd        = ($urandom % 32) == 0;
                apply_cycle(lv, req, fv, f, rd);
                cyc++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h5e67ca12));
        errors       = 0;
        cycle_cnt    = 0;
        rst          = 1'b0;
        lookup_valid = 1'b0;
        lookup       = '0;
        train_valid  = 1'b0;
        train        = '0;
        finish_valid = 1'b0;
        finish       = '0;
        redirect     = 1'b0;
        cur_test     = "reset_idle";
        model_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        for (int i = 0; i < 8; i++) begin
            send_lookup(make_lane(mem_op_e'(i % 3), i * 8, i),
                        make_lane(mem_op_e'((i + 1) % 3), i * 8 + 1, i + 8));
        end
        drain_responses();

        cur_test = "alloc";
        send_train(10, 11); // set 0.
        send_train(20, 21); // set 1.
        send_lookup(make_lane(op_store, 11, 5), make_lane(op_none, 0, 0));
        send_lookup(make_lane(op_none, 0, 0), make_lane(op_none, 0, 0));
        send_lookup(make_lane(op_load, 10, 9), make_lane(op_load, 40, 10));
        drain_responses();

        cur_test = "lane_fwd";
        send_lookup(make_lane(op_store, 11, 12), make_lane(op_load, 10, 13));
        send_lookup(make_lane(op_load, 10, 14), make_lane(op_store, 11, 15));
        drain_responses();

        cur_test = "finish_redirect";
        send_finish(0, 15);
        send_lookup(make_lane(op_load, 10, 16), make_lane(op_none, 0, 0));
        send_lookup(make_lane(op_store, 11, 20), make_lane(op_none, 0, 0));
        idle_cycles(2);
        send_finish(0, 3); // stale rob index.
        send_lookup(make_lane(op_load, 10, 21), make_lane(op_none, 0, 0));
        send_lookup(make_lane(op_store, 21, 30), make_lane(op_none, 0, 0));
        idle_cycles(2);
        apply_cycle(1'b0, '0, 1'b0, '0, 1'b1);
        send_lookup(make_lane(op_load, 10, 31), make_lane(op_load, 20, 32));
        drain_responses();

        cur_test = "merge_clear";
        send_train(21, 10); // sets 1 and 0 merge into 0.
        send_lookup(make_lane(op_store, 11, 33), make_lane(op_none, 0, 0));
        idle_cycles(2);
        send_lookup(make_lane(op_load, 21, 34), make_lane(op_none, 0, 0));
        for (int i = 0; i < 6; i++) begin
            send_train(10, 11);
        end
        // seven trainings hit a set so far.
        send_lookup(make_lane(op_store, 10, 35), make_lane(op_none, 0, 0));
        idle_cycles(2);
        send_lookup(make_lane(op_load, 21, 36), make_lane(op_none, 0, 0));
        send_train(10, 11);
        send_lookup(make_lane(op_store, 10, 40), make_lane(op_none, 0, 0));
        idle_cycles(2);
        send_lookup(make_lane(op_load, 21, 41), make_lane(op_none, 0, 0));
        drain_responses();

        cur_test = "random";
        run_random(400);
        drain_responses();

        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: mem_dep_pred.sv
`timescale 1ns/1ps

module mem_dep_pred (
    input  logic clk,
    input  logic rst,
    input  logic lookup_valid,
    input  ss_types_pkg::lookup_req_t lookup,
    input  logic train_valid,
    input  ss_types_pkg::train_req_t train,
    input  logic finish_valid,
    input  ss_types_pkg::finish_req_t finish,
    input  logic redirect,
    output logic rsp_valid,
    output ss_types_pkg::dep_rsp_t rsp
);

    import ss_cfg_pkg::*;
    import ss_types_pkg::*;

    logic [fetch_width-1:0][ssit_idx_w-1:0] raddr;
    ssit_entry_t [fetch_width-1:0]          ssit_rdata;
    logic [fetch_width-1:0][ssid_w-1:0]     lfst_rd_ssid;
    logic [fetch_width-1:0]                 lfst_rd_en;
    logic [fetch_width-1:0][rob_idx_w-1:0]  lfst_rd_idx;
    lfst_wr_t [fetch_width-1:0]             lfst_wr;

    ss_dispatch ss_dispatch_i (
        .clk, .rst, .lookup_valid, .lookup, .raddr, .ssit_rdata,
        .lfst_rd_ssid, .lfst_rd_en, .lfst_rd_idx, .lfst_wr, .rsp_valid, .rsp
    );

    store_set store_set_i (
        .clk, .rst, .lookup_valid, .raddr, .ssit_rdata, .train_valid, .train,
        .finish_valid, .finish, .redirect, .lfst_wr, .lfst_rd_ssid,
        .lfst_rd_en, .lfst_rd_idx
    );

endmodule

// File: ss_cfg_pkg.sv
package ss_cfg_pkg;

    // ----------------------------------------
    // front end
    // ----------------------------------------
    localparam int fetch_width = 2; // lanes per fetch group.

    // ----------------------------------------
    // tables
    // ----------------------------------------
    // ssit is indexed by the caller's pc hash.
    localparam int ssit_size  = 64;
    localparam int ssit_idx_w = 6;

    // one lfst entry per store set.
    localparam int lfst_size = 16;
    localparam int ssid_w    = 4;

    localparam int rob_idx_w = 6;

    // ----------------------------------------
    // periodic clear
    // ----------------------------------------
    // ssit is cleared after 2**ssit_clear_w trainings that hit a set.
    localparam int ssit_clear_w = 3;

endpackage

// File: ss_dispatch.sv
`timescale 1ns/1ps

module ss_dispatch (
    input  logic clk,
    input  logic rst,
    input  logic lookup_valid,
    input  ss_types_pkg::lookup_req_t lookup,
    output logic [ss_cfg_pkg::fetch_width-1:0][ss_cfg_pkg::ssit_idx_w-1:0] raddr,
    input  ss_types_pkg::ssit_entry_t [ss_cfg_pkg::fetch_width-1:0] ssit_rdata,
    output logic [ss_cfg_pkg::fetch_width-1:0][ss_cfg_pkg::ssid_w-1:0] lfst_rd_ssid,
    input  logic [ss_cfg_pkg::fetch_width-1:0] lfst_rd_en,
    input  logic [ss_cfg_pkg::fetch_width-1:0][ss_cfg_pkg::rob_idx_w-1:0] lfst_rd_idx,
    output ss_types_pkg::lfst_wr_t [ss_cfg_pkg::fetch_width-1:0] lfst_wr,
    output logic rsp_valid,
    output ss_types_pkg::dep_rsp_t rsp
);

    import ss_cfg_pkg::*;
    import ss_types_pkg::*;

    logic                                  s1_valid;
    lookup_req_t                           s1_req;
    logic                                  s2_valid;
    mem_op_e [fetch_width-1:0]             s2_op;
    logic [fetch_width-1:0][rob_idx_w-1:0] s2_rob;
    logic [fetch_width-1:0]                lane_hit;
    logic                                  fwd;
    dep_rsp_t                              dep;

    // ----------------------------------------
    // pipeline
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= lookup_valid;
            s2_valid  <= s1_valid;
            rsp_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_req <= lookup;
        for (int i = 0; i < fetch_width; i++) begin
            s2_op[i]  <= s1_req[i].op; // lines up with ssit data.
            s2_rob[i] <= s1_req[i].rob_idx;
        end
        rsp <= dep;
    end

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            raddr[i] = s1_req[i].ssit_idx;
        end
    end

    // ----------------------------------------
    // lfst read and write
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            lane_hit[i]         = s2_valid && (s2_op[i] != op_none) && ssit_rdata[i].en;
            lfst_rd_ssid[i]     = ssit_rdata[i].ssid;
            dep[i].dep_valid    = lane_hit[i] & lfst_rd_en[i];
            dep[i].dep_rob_idx  = dep[i].dep_valid ? lfst_rd_idx[i] : '0;
            lfst_wr[i].we       = lane_hit[i] && (s2_op[i] == op_store);
            lfst_wr[i].ssid     = ssit_rdata[i].ssid;
            lfst_wr[i].rob_idx  = s2_rob[i];
        end

        // lane 0 store is younger than anything in the lfst.
        fwd = lane_hit[0] && lane_hit[1] && (s2_op[0] == op_store) &&
              (ssit_rdata[0].ssid == ssit_rdata[1].ssid);
        if (fwd) begin
            dep[1].dep_valid   = 1'b1;
            dep[1].dep_rob_idx = s2_rob[0];
        end
    end

    a_rsp_follows_lookup: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |-> $past(lookup_valid, 3));

endmodule

// File: ss_types_pkg.sv
package ss_types_pkg;

    import ss_cfg_pkg::*;

    typedef struct packed {
        logic              en;
        logic [ssid_w-1:0] ssid;
    } ssit_entry_t;

    typedef enum logic [1:0] {
        op_none,
        op_load,
        op_store
    } mem_op_e;

    // ----------------------------------------
    // lookup side
    // ----------------------------------------
    typedef struct packed {
        mem_op_e                op;
        logic [ssit_idx_w-1:0]  ssit_idx;
        logic [rob_idx_w-1:0]   rob_idx;
    } lookup_lane_t;

    typedef lookup_lane_t [fetch_width-1:0] lookup_req_t;

    typedef struct packed {
        logic                 we;
        logic [ssid_w-1:0]    ssid;
        logic [rob_idx_w-1:0] rob_idx;
    } lfst_wr_t;

    // ----------------------------------------
    // training and execute side
    // ----------------------------------------
    typedef struct packed {
        logic [ssit_idx_w-1:0] ld_idx;
        logic [ssit_idx_w-1:0] st_idx;
    } train_req_t;

    typedef struct packed {
        logic [ssid_w-1:0]    ssid;
        logic [rob_idx_w-1:0] rob_idx;
    } finish_req_t;

    typedef struct packed {
        logic                 dep_valid;
        logic [rob_idx_w-1:0] dep_rob_idx;
    } dep_lane_t;

    typedef dep_lane_t [fetch_width-1:0] dep_rsp_t;

endpackage

// File: ssit_ram.sv
`timescale 1ns/1ps

module ssit_ram #(
    parameter int width = 5,
    parameter int depth = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic [ss_cfg_pkg::fetch_width-1:0][$clog2(depth)-1:0] raddr,
    output ss_types_pkg::ssit_entry_t [ss_cfg_pkg::fetch_width-1:0] rdata,
    input  logic [1:0] we,
    input  logic [1:0][$clog2(depth)-1:0] waddr,
    input  ss_types_pkg::ssit_entry_t wdata
);

    import ss_cfg_pkg::*;
    import ss_types_pkg::*;

    // en bit is the msb of an entry, the rest is the set id.
    logic [depth-1:0] en_q;
    logic [width-2:0] data_q [depth];

    // ----------------------------------------
    // valid bits
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            en_q <= '0;
        end else if (clear) begin
            en_q <= '0; // whole table in one cycle.
        end else begin
            if (we[0]) begin
                en_q[waddr[0]] <= wdata[width-1];
            end
            if (we[1]) begin
                en_q[waddr[1]] <= wdata[width-1]; // port 1 wins.
            end
        end
    end

    // ----------------------------------------
    // set ids
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (we[0]) begin
            data_q[waddr[0]] <= wdata[width-2:0];
        end
        if (we[1]) begin
            data_q[waddr[1]] <= wdata[width-2:0];
        end
    end

    // registered reads, old data on a same-cycle write.
    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_width; i++) begin
            rdata[i] <= {en_q[raddr[i]], data_q[raddr[i]]};
        end
    end

endmodule

// File: store_set.sv
`timescale 1ns/1ps

module store_set (
    input  logic clk,
    input  logic rst,
    input  logic lookup_valid,
    input  logic [ss_cfg_pkg::fetch_width-1:0][ss_cfg_pkg::ssit_idx_w-1:0] raddr,
    output ss_types_pkg::ssit_entry_t [ss_cfg_pkg::fetch_width-1:0] ssit_rdata,
    input  logic train_valid,
    input  ss_types_pkg::train_req_t train,
    input  logic finish_valid,
    input  ss_types_pkg::finish_req_t finish,
    input  logic redirect,
    input  ss_types_pkg::lfst_wr_t [ss_cfg_pkg::fetch_width-1:0] lfst_wr,
    input  logic [ss_cfg_pkg::fetch_width-1:0][ss_cfg_pkg::ssid_w-1:0] lfst_rd_ssid,
    output logic [ss_cfg_pkg::fetch_width-1:0] lfst_rd_en,
    output logic [ss_cfg_pkg::fetch_width-1:0][ss_cfg_pkg::rob_idx_w-1:0] lfst_rd_idx
);

    import ss_cfg_pkg::*;
    import ss_types_pkg::*;

    logic [fetch_width-1:0][ssit_idx_w-1:0] ram_raddr;
    logic                                   train_q;
    logic [1:0][ssit_idx_w-1:0]             train_waddr_q;
    logic [1:0]                             wmask;
    logic [1:0]                             ssit_we;
    ssit_entry_t                            ssit_wdata;
    logic                                   alloc;
    logic                                   any_valid;
    logic [ssid_w-1:0]                      set_cnt;
    logic [ssit_clear_w-1:0]                clear_cnt;
    logic                                   ssit_clear;

    // ----------------------------------------
    // ssit training
    // ----------------------------------------
    // training reads the load on port 0 and the store on port 1.
    always_comb begin
        ram_raddr = raddr;
        if (train_valid) begin
            ram_raddr[0] = train.ld_idx;
            ram_raddr[1] = train.st_idx;
        end
    end

    always_comb begin
        alloc = 1'b0;
        case ({ssit_rdata[1].en, ssit_rdata[0].en})
            2'b00: begin
                wmask            = 2'b11;
                ssit_wdata.ssid  = set_cnt; // new set.
                alloc            = 1'b1;
            end
            2'b01: begin
                wmask            = 2'b10; // store joins load's set.
                ssit_wdata.ssid  = ssit_rdata[0].ssid;
            end
            2'b10: begin
                wmask            = 2'b01;
                ssit_wdata.ssid  = ssit_rdata[1].ssid;
            end
            2'b11: begin
                wmask = 2'b11;
                // merge into the lower set.
                if (ssit_rdata[0].ssid < ssit_rdata[1].ssid) begin
                    ssit_wdata.ssid = ssit_rdata[0].ssid;
                end else begin
                    ssit_wdata.ssid = ssit_rdata[1].ssid;
                end
            end
            default: begin
                wmask           = 2'b00;
                ssit_wdata.ssid = set_cnt;
            end
        endcase
        ssit_wdata.en = 1'b1;
    end

    assign ssit_we   = wmask & {2{train_q}};
    assign any_valid = ssit_rdata[0].en | ssit_rdata[1].en;

    always_ff @(posedge clk) begin
        train_waddr_q[0] <= train.ld_idx;
        train_waddr_q[1] <= train.st_idx;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            train_q    <= 1'b0;
            set_cnt    <= '0;
            clear_cnt  <= '0;
            ssit_clear <= 1'b0;
        end else begin
            train_q <= train_valid;
            if (train_q && alloc) begin
                set_cnt <= set_cnt + 1'b1;
            end
            if (train_q && any_valid) begin
                clear_cnt <= clear_cnt + 1'b1;
            end
            ssit_clear <= train_q & any_valid & (&clear_cnt); // on wrap.
        end
    end

    ssit_ram #(
        .width($bits(ssit_entry_t)),
        .depth(ssit_size)
    ) ssit_ram_i (
        .clk   (clk),
        .rst   (rst),
        .clear (ssit_clear),
        .raddr (ram_raddr),
        .rdata (ssit_rdata),
        .we    (ssit_we),
        .waddr (train_waddr_q),
        .wdata (ssit_wdata)
    );

    // ----------------------------------------
    // lfst
    // ----------------------------------------
    logic [lfst_size-1:0] lfst_en;
    logic [rob_idx_w-1:0] lfst_idx [lfst_size];
    logic [lfst_size-1:0] wr_mask;
    logic [lfst_size-1:0] fin_mask;
    logic                 fin_hit;

    // only the youngest store of the set may clear it.
    assign fin_hit = finish_valid && (lfst_idx[finish.ssid] == finish.rob_idx);

    always_comb begin
        wr_mask  = '0;
        fin_mask = '0;
        for (int i = 0; i < fetch_width; i++) begin
            if (lfst_wr[i].we) begin
                wr_mask[lfst_wr[i].ssid] = 1'b1;
            end
        end
        fin_mask[finish.ssid] = fin_hit;
    end

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            lfst_rd_en[i]  = lfst_en[lfst_rd_ssid[i]] &
                             ~(fin_hit && (lfst_rd_ssid[i] == finish.ssid));
            lfst_rd_idx[i] = lfst_idx[lfst_rd_ssid[i]];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lfst_en <= '0;
        end else if (redirect) begin
            lfst_en <= '0;
        end else begin
            lfst_en <= (lfst_en | wr_mask) & ~fin_mask;
        end
    end

    // lane 1 is written last and wins.
    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (lfst_wr[i].we) begin
                lfst_idx[lfst_wr[i].ssid] <= lfst_wr[i].rob_idx;
            end
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_train_no_lookup: assert property (@(posedge clk) disable iff (!rst)
        train_valid |-> !lookup_valid && !$past(lookup_valid));

endmodule
